/* bench/kpu_input.txt */
// Words 0 to 63 hold the program, one instruction per word (offset rb ra op)
// Word 64 holds the store count, then store address and data pairs in order
// ALU ops on LDI values, ADD SUB AND OR XOR
13570089 7a5c00c9 000010c1 010000ca
100000c9 000010c2 010100ca 7a5c00c9
000010c3 010200ca 7a5c00c9 000010c4
010300ca 7a5c00c9 000010c5 010400ca
// Shifts of ffff8421 by 0, 1 and 31
00000149 00010189 001f01c9 842100c9
000028c6 011000ca 000028c7 011100ca
000028c8 011200ca 000030c6 011300ca
842100c9 000030c7 011400ca 842100c9
000030c8 011500ca 842100c9 000038c6
011600ca 842100c9 000038c7 011700ca
842100c9 000038c8 011800ca
// LDI sign extension, bit 15 set then clear
80000209 0119020a 7fff0209 011a020a
// Countdown from 3 with SUB and BZ, then HALT
00030249 00010289 00005242 0120024a
00002a86 0002000b 00002945 fffa000b
00000000
@40
00000013
00000100 00008db3 00000101 fffffca9
00000102 00001254 00000103 00007b5f
00000104 0000690b 00000110 ffff8421
00000111 ffff8421 00000112 ffff8421
00000113 ffff0842 00000114 7fffc210
00000115 ffffc210 00000116 80000000
00000117 00000001 00000118 ffffffff
00000119 ffff8000 0000011a 00007fff
00000120 00000002 00000120 00000001
00000120 00000000

/* flist.f */
hw/kpu_isa_pkg.sv
hw/kpu_uarch_pkg.sv
hw/kpu_alu.sv
hw/kpu_shifter.sv
hw/kpu_regfile.sv
hw/kpu_operands.sv
hw/kpu_control.sv
hw/kpu_core.sv
bench/kpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module kpu_tb -f flist.f -o Vkpu_tb
./obj_dir/Vkpu_tb | tee sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "Run ended without a result line, see sim.log"
  exit 1
fi
echo "Run passed"

/* bench/kpu_tb.sv */
`timescale 1ns/1ps

module kpu_tb
  import kpu_isa_pkg::*;
  import kpu_uarch_pkg::*;
();

  localparam int unsigned SEED = 32'haedd0e13;
  localparam int IMAGE_WORDS   = 64;
  localparam int MAX_STORES    = 32;
  // Store count follows the image and the address and data pairs follow it
  localparam int COUNT_WORD    = IMAGE_WORDS;
  localparam int STORE_BASE    = IMAGE_WORDS + 1;
  localparam int CYCLE_LIMIT   = 64 * IMAGE_WORDS + 256;
  localparam int QUIET_CYCLES  = 20;

  logic    clk;
  logic    rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    halted;

  logic [31:0] image [0:STORE_BASE + 2*MAX_STORES - 1];

  int   exp_cnt;
  int   store_cnt;
  int   errors;
  int   passes;
  int   cycles;
  int   wait_left;
  int   busy_after_halt;
  logic in_reset;
  logic halt_fetched;

  kpu_core DUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_rsp (wb_rsp),
    .wb_req (wb_req),
    .halted (halted)
  );

  always #5 clk = ~clk;

  task automatic check_store(input wb_req_t req, input int idx);
    logic [31:0] exp_adr;
    logic [31:0] exp_dat;
    if (idx >= exp_cnt) begin
      errors++;
      $display("Store %0d to address %h was not expected", idx, req.adr);
    end else begin
      exp_adr = image[STORE_BASE + 2*idx];
      exp_dat = image[STORE_BASE + 2*idx + 1];
      if (req.adr !== exp_adr) begin
        errors++;
        $display("Fail store %0d wb_req.adr: got %h expected %h", idx, req.adr, exp_adr);
      end else if (req.dat_w !== exp_dat) begin
        errors++;
        $display("Fail store %0d wb_req.dat_w: got %h expected %h", idx, req.dat_w, exp_dat);
      end else begin
        passes++;
        $display("store %0d adr %h data %h ok", idx, req.adr, req.dat_w);
      end
    end
  endtask

  task automatic check_halt(input logic halt_v, input int n_stores);
    if (halt_v !== 1'b1) begin
      errors++;
      $display("Fail halted: got %h expected 1", halt_v);
    end else if (n_stores != exp_cnt) begin
      errors++;
      $display("Fail store count: got %h expected %h", n_stores, exp_cnt);
    end else begin
      passes++;
      $display("halt after %0d stores ok", n_stores);
    end
  endtask

  // Fetches are served from the image and stores go to the store check
  task automatic serve_request();
    instr_t fetched;
    if (wb_req.we) begin
      check_store(wb_req, store_cnt);
      store_cnt++;
    end else if (wb_req.adr < IMAGE_WORDS) begin
      wb_rsp.dat_r = image[int'(wb_req.adr[5:0])];
    end else begin
      errors++;
      wb_rsp.dat_r = '0;
      $display("Fetch from address %h lies outside the program image", wb_req.adr);
    end
    if (!wb_req.we) begin
      fetched = instr_t'(wb_rsp.dat_r);
      if (fetched.op == OP_HALT) begin
        halt_fetched = 1'b1;
      end
    end
    wb_rsp.ack = 1'b1;
  endtask

  // Wishbone slave with 0 to 3 wait states per access
  always @(posedge clk) begin
    in_reset = !rst_n;
    #1;
    if (in_reset) begin
      wb_rsp    = '0;
      wait_left = -1;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack = 1'b0;
      if (wb_req.cyc || wb_req.stb) begin
        errors++;
        $display("Master kept cyc or stb high in the cycle after ack");
      end
    end else if (wb_req.cyc !== wb_req.stb) begin
      errors++;
      $display("Master drove cyc and stb to different levels");
    end else if (wb_req.cyc) begin
      if (wait_left < 0) begin
        wait_left = $urandom_range(3, 0);
      end
      if (wait_left == 0) begin
        serve_request();
        wait_left = -1;
      end else begin
        wait_left--;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout, the core did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    wb_rsp          = '0;
    errors          = 0;
    passes          = 0;
    store_cnt       = 0;
    cycles          = 0;
    wait_left       = -1;
    busy_after_halt = 0;
    halt_fetched    = 1'b0;
    void'($urandom(SEED));
    $readmemh("bench/kpu_input.txt", image);
    exp_cnt = int'(image[COUNT_WORD]);
    if (exp_cnt > MAX_STORES) begin
      errors++;
      $display("Input file lists %0d stores, more than the bench can hold", exp_cnt);
      exp_cnt = MAX_STORES;
    end

    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    // Program runs until the HALT word is fetched
    while (!halt_fetched) @(negedge clk);
    // Core sees the ack on the next edge and raises halted one cycle later
    repeat (2) @(negedge clk);
    check_halt(halted, store_cnt);

    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      if (wb_req.cyc || wb_req.stb || !halted) begin
        busy_after_halt++;
      end
    end
    if (busy_after_halt != 0) begin
      errors++;
      $display("Core left halt or started a bus cycle in %0d of %0d cycles after halt",
               busy_after_halt, QUIET_CYCLES);
    end else begin
      passes++;
      $display("bus quiet for %0d cycles after halt ok", QUIET_CYCLES);
    end

    $display("Tests passed %0d, failed %0d", passes, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* hw/kpu_core.sv */
`timescale 1ns/1ps

module kpu_core
  import kpu_isa_pkg::*;
  import kpu_uarch_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  wb_rsp_t wb_rsp,
  output wb_req_t wb_req,
  output logic    halted
);

  // Shared internal bus and the blocks around it
  logic [XLEN-1:0] bus;
  logic [XLEN-1:0] tmp0;
  logic [XLEN-1:0] tmp1;
  logic [XLEN-1:0] reg_rd;
  logic [XLEN-1:0] alu_y;
  logic [XLEN-1:0] shift_y;
  logic [XLEN-1:0] imm;
  logic            zero;
  ctrl_t           ctrl;

  kpu_control u_control (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_rsp (wb_rsp),
    .zero   (zero),
    .tmp0   (tmp0),
    .wb_req (wb_req),
    .ctrl   (ctrl),
    .imm    (imm),
    .halted (halted)
  );

  kpu_operands u_operands (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .reg_rd  (reg_rd),
    .alu_y   (alu_y),
    .shift_y (shift_y),
    .imm     (imm),
    .bus     (bus),
    .tmp0    (tmp0),
    .tmp1    (tmp1)
  );

  kpu_regfile u_regfile (
    .clk    (clk),
    .ctrl   (ctrl),
    .bus    (bus),
    .reg_rd (reg_rd)
  );

  kpu_alu u_alu (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .a     (tmp0),
    .b     (tmp1),
    .y     (alu_y),
    .zero  (zero)
  );

  // Shift distance from the low bits of the second operand
  kpu_shifter u_shifter (
    .ctrl   (ctrl),
    .a      (tmp0),
    .amount (tmp1[4:0]),
    .y      (shift_y)
  );

endmodule

/* hw/kpu_control.sv */
`timescale 1ns/1ps

module kpu_control
  import kpu_isa_pkg::*;
  import kpu_uarch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  wb_rsp_t         wb_rsp,
  input  logic            zero,
  input  logic [XLEN-1:0] tmp0,
  output wb_req_t         wb_req,
  output ctrl_t           ctrl,
  output logic [XLEN-1:0] imm,
  output logic            halted
);

  typedef enum logic [3:0] {
    S_FETCH, S_DECODE, S_LOAD_A, S_LOAD_B, S_EXEC,
    S_LDI, S_STORE, S_GAP, S_BRANCH, S_HALT
  } state_e;

  state_e           state;
  logic [ADR_W-1:0] pc;
  instr_t           ir;
  logic             is_shift;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_FETCH;
      pc    <= '0;
    end else begin
      case (state)
        S_FETCH: begin
          if (wb_rsp.ack) begin
            state <= S_DECODE;
            pc    <= pc + 1'b1;
          end
        end
        S_DECODE: begin
          case (ir.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SHL, OP_SHR, OP_SRA, OP_ST: state <= S_LOAD_A;
            OP_LDI:  state <= S_LDI;
            OP_BZ:   state <= S_BRANCH;
            OP_HALT: state <= S_HALT;
            // Unknown opcodes are skipped
            default: state <= S_FETCH;
          endcase
        end
        S_LOAD_A: state <= (ir.op == OP_ST) ? S_STORE : S_LOAD_B;
        S_LOAD_B: state <= S_EXEC;
        S_STORE: begin
          if (wb_rsp.ack) begin
            state <= S_GAP;
          end
        end
        S_BRANCH: begin
          // Target is relative to the next instruction
          if (zero) begin
            pc <= pc + imm;
          end
          state <= S_FETCH;
        end
        S_HALT:  state <= S_HALT;
        default: state <= S_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH && wb_rsp.ack) begin
      ir <= instr_t'(wb_rsp.dat_r);
    end
  end

  assign imm      = {{(XLEN-IMM_W){ir.offset[IMM_W-1]}}, ir.offset};
  assign halted   = (state == S_HALT);
  assign is_shift = ir.op inside {OP_SHL, OP_SHR, OP_SRA};

  // Bus cycle lasts exactly as long as the fetch or store state
  always_comb begin
    wb_req.cyc   = (state == S_FETCH) || (state == S_STORE);
    wb_req.stb   = wb_req.cyc;
    wb_req.we    = (state == S_STORE);
    wb_req.adr   = (state == S_STORE) ? ADR_W'(ir.offset) : pc;
    wb_req.dat_w = tmp0;
  end

  always_comb begin
    ctrl         = '0;
    ctrl.reg_sel = ir.ra;
    case (ir.op)
      OP_SUB:  ctrl.alu_op = ALU_SUB;
      OP_AND:  ctrl.alu_op = ALU_AND;
      OP_OR:   ctrl.alu_op = ALU_OR;
      OP_XOR:  ctrl.alu_op = ALU_XOR;
      default: ctrl.alu_op = ALU_ADD;
    endcase
    case (ir.op)
      OP_SHR:  ctrl.shift_op = SH_SHR;
      OP_SRA:  ctrl.shift_op = SH_SRA;
      default: ctrl.shift_op = SH_SHL;
    endcase
    case (state)
      S_LOAD_A: ctrl.tmp0_le = 1'b1;
      S_LOAD_B: begin
        ctrl.reg_sel = ir.rb;
        ctrl.tmp1_le = 1'b1;
      end
      S_EXEC: begin
        ctrl.bus_src = is_shift ? SRC_SHIFT : SRC_ALU;
        ctrl.reg_we  = 1'b1;
        // Shifts leave the zero flag alone
        ctrl.flag_le = !is_shift;
      end
      S_LDI: begin
        ctrl.bus_src = SRC_IMM;
        ctrl.reg_we  = 1'b1;
      end
      default: ;
    endcase
  end

  // Request must hold still until the slave answers
  a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req.stb && !wb_rsp.ack) |=> wb_req.stb && $stable(wb_req.adr) && $stable(wb_req.we));

endmodule

/* hw/kpu_operands.sv */
`timescale 1ns/1ps

module kpu_operands
  import kpu_isa_pkg::*;
  import kpu_uarch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  ctrl_t           ctrl,
  input  logic [XLEN-1:0] reg_rd,
  input  logic [XLEN-1:0] alu_y,
  input  logic [XLEN-1:0] shift_y,
  input  logic [XLEN-1:0] imm,
  output logic [XLEN-1:0] bus,
  output logic [XLEN-1:0] tmp0,
  output logic [XLEN-1:0] tmp1
);

  // Scratch latches, not visible to the instruction set
  always_ff @(posedge clk) begin
    if (ctrl.tmp0_le) begin
      tmp0 <= bus;
    end
    if (ctrl.tmp1_le) begin
      tmp1 <= bus;
    end
  end

  // Select comes straight from the sequencer state register
  always_comb begin
    case (ctrl.bus_src)
      SRC_TMP0:  bus = tmp0;
      SRC_TMP1:  bus = tmp1;
      SRC_ALU:   bus = alu_y;
      SRC_SHIFT: bus = shift_y;
      SRC_IMM:   bus = imm;
      default:   bus = reg_rd;
    endcase
  end

  a_no_self_load: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.tmp0_le && ctrl.bus_src == SRC_TMP0) &&
    !(ctrl.tmp1_le && ctrl.bus_src == SRC_TMP1));

  a_src_legal: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.bus_src inside {SRC_REG, SRC_TMP0, SRC_TMP1, SRC_ALU, SRC_SHIFT, SRC_IMM});

endmodule

/* hw/kpu_regfile.sv */
`timescale 1ns/1ps

module kpu_regfile
  import kpu_isa_pkg::*;
  import kpu_uarch_pkg::*;
(
  input  logic            clk,
  input  ctrl_t           ctrl,
  input  logic [XLEN-1:0] bus,
  output logic [XLEN-1:0] reg_rd
);

  logic [XLEN-1:0] regs [NREGS];

  // Single port, read and write share the selected index
  always_ff @(posedge clk) begin
    if (ctrl.reg_we) begin
      regs[ctrl.reg_sel] <= bus;
    end
  end

  assign reg_rd = regs[ctrl.reg_sel];

endmodule

/* hw/kpu_shifter.sv */
`timescale 1ns/1ps

module kpu_shifter
  import kpu_isa_pkg::*;
  import kpu_uarch_pkg::*;
(
  input  ctrl_t           ctrl,
  input  logic [XLEN-1:0] a,
  input  logic [4:0]      amount,
  output logic [XLEN-1:0] y
);

  always_comb begin
    case (ctrl.shift_op)
      SH_SHR:  y = a >> amount;
      // Arithmetic shift fills from the sign bit
      SH_SRA:  y = $unsigned($signed(a) >>> amount);
      default: y = a << amount;
    endcase
  end

endmodule

/* hw/kpu_alu.sv */
`timescale 1ns/1ps

module kpu_alu
  import kpu_isa_pkg::*;
  import kpu_uarch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  ctrl_t           ctrl,
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  output logic [XLEN-1:0] y,
  output logic            zero
);

  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB: y = a - b;
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      default: y = a + b;
    endcase
  end

  // Flag is sampled only when the sequencer asks, so BZ sees the last ALU op
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      zero <= 1'b0;
    end else if (ctrl.flag_le) begin
      zero <= (y == '0);
    end
  end

endmodule

/* hw/kpu_uarch_pkg.sv */
package kpu_uarch_pkg;

  import kpu_isa_pkg::*;

  // Word address width on the Wishbone port
  localparam int ADR_W = 32;

  // One block owns the internal bus per cycle
  typedef enum logic [2:0] {
    SRC_REG   = 3'd0,
    SRC_TMP0  = 3'd1,
    SRC_TMP1  = 3'd2,
    SRC_ALU   = 3'd3,
    SRC_SHIFT = 3'd4,
    SRC_IMM   = 3'd5
  } bus_src_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  typedef enum logic [1:0] {
    SH_SHL = 2'd0,
    SH_SHR = 2'd1,
    SH_SRA = 2'd2
  } shift_op_e;

  // Control word issued by the sequencer every cycle
  typedef struct packed {
    bus_src_e         bus_src;
    logic [REG_W-1:0] reg_sel;
    logic             reg_we;
    logic             tmp0_le;
    logic             tmp1_le;
    alu_op_e          alu_op;
    shift_op_e        shift_op;
    logic             flag_le;
  } ctrl_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [XLEN-1:0]  dat_w;
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat_r;
  } wb_rsp_t;

endpackage

/* hw/kpu_isa_pkg.sv */
package kpu_isa_pkg;

  // Data path and register file geometry
  localparam int XLEN  = 32;
  localparam int NREGS = 32;
  localparam int REG_W = $clog2(NREGS);
  localparam int IMM_W = 16;
  localparam int OP_W  = 6;

  // Opcode space, zero decodes as HALT so blank memory stops the core
  typedef enum logic [OP_W-1:0] {
    OP_HALT = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_SHL  = 6'h06,
    OP_SHR  = 6'h07,
    OP_SRA  = 6'h08,
    OP_LDI  = 6'h09,
    OP_ST   = 6'h0a,
    OP_BZ   = 6'h0b
  } opcode_e;

  // Instruction word, offset in the top half and opcode in the low bits
  typedef struct packed {
    logic [IMM_W-1:0] offset;
    logic [REG_W-1:0] rb;
    logic [REG_W-1:0] ra;
    opcode_e          op;
  } instr_t;

endpackage
